// ==== all.f ====
hdl/jtag_pkg.sv
hdl/bridge_cfg_pkg.sv
hdl/jtag_dr_if.sv
hdl/tck_edge_timer.sv
hdl/jtag_dr_ctrl.sv
hdl/jtag_dr_path.sv
hdl/jtag_dbg_bridge.sv
test/tb_jtag_dbg_bridge.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -Wall -Wno-fatal
TOP      = tb_jtag_dbg_bridge
FILELIST = all.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "No errors" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== test/tb_jtag_dbg_bridge.sv ====
// JTAG bridge testbench
`default_nettype none

module tb_jtag_dbg_bridge;
	import jtag_pkg::*;

	localparam int HALF_TCK     = 12; // clk48m cycles per tck half-period
	localparam int STROBE_LIMIT = 40; // cycles allowed from update rise to strobe
	localparam int NUM_SCANS    = 18; // scan-length steps in the whole run
	localparam int TIMEOUT      = (NUM_SCANS * 36 * 24 + 1000) * 100;

	logic     clk48m;
	logic     jrstn;
	logic     jtck;
	logic     jtdi;
	logic     jshift;
	logic     jupdate;
	logic     jce1;
	logic     jce2;
	dr_word_t dbgreg_in;
	logic     dbgreg_sel;
	logic     dbgreg_strobe;

	integer   seed;
	int       err_count    = 0;
	int       check_count  = 0;
	int       strobe_count = 0;
	dr_word_t last_word; // expected dbgreg_in
	logic     last_sel;  // expected chain select

	jtag_dbg_bridge jtag_dbg_bridge_inst (
		.clk48m        (clk48m),
		.jrstn         (jrstn),
		.jtck          (jtck),
		.jtdi          (jtdi),
		.jshift        (jshift),
		.jupdate       (jupdate),
		.jce1          (jce1),
		.jce2          (jce2),
		.dbgreg_in     (dbgreg_in),
		.dbgreg_sel    (dbgreg_sel),
		.dbgreg_strobe (dbgreg_strobe)
	);

	initial clk48m = 1'b0;
	always #50 clk48m = ~clk48m;

	// every strobe pulse seen on the system side
	always @(posedge clk48m) begin
		if (jrstn && dbgreg_strobe)
			strobe_count <= strobe_count + 1;
	end

	task automatic check_outputs(input dr_word_t exp_word, input logic exp_sel);
		check_count++;
		if (dbgreg_in !== exp_word) begin
			err_count++;
			$display("[FAIL] %0t: dbgreg_in %h, expected %h", $time, dbgreg_in, exp_word);
		end
		check_count++;
		if (dbgreg_sel !== exp_sel) begin
			err_count++;
			$display("[FAIL] %0t: dbgreg_sel %b, expected %b", $time, dbgreg_sel, exp_sel);
		end
	endtask

	task automatic check_strobe_count(input int exp_count);
		check_count++;
		if (strobe_count != exp_count) begin
			err_count++;
			$display("[FAIL] %0t: %0d strobes seen, expected %0d", $time, strobe_count,
				exp_count);
		end
	endtask

	// one full tck period, pins already set while tck is low
	task automatic tck_pulse;
		repeat (HALF_TCK) @(negedge clk48m);
		jtck = 1'b1;
		repeat (HALF_TCK) @(negedge clk48m);
		jtck = 1'b0;
	endtask

	task automatic shift_word(input dr_word_t word, input logic ce1, input logic ce2);
		jce1   = ce1;
		jce2   = ce2;
		jshift = 1'b1;
		jtdi   = 1'b0;
		tck_pulse(); // first rise only arms the shift
		for (int i = 0; i < DR_WIDTH; i++) begin
			jtdi = word[i];
			if (i == DR_WIDTH - 1)
				jshift = 1'b0; // no shift armed after the last bit
			tck_pulse();
		end
		jce1 = 1'b0;
		jce2 = 1'b0;
		if (ce1 || ce2)
			last_sel = ce2;
	endtask

	// tck rise with jupdate high, then wait for the strobe
	task automatic update_word(input dr_word_t exp_word);
		int waited;
		bit seen;
		waited  = 0;
		seen    = 1'b0;
		jupdate = 1'b1;
		repeat (HALF_TCK) @(negedge clk48m);
		jtck = 1'b1;
		while (!seen && waited < STROBE_LIMIT) begin
			@(negedge clk48m);
			waited++;
			if (dbgreg_strobe)
				seen = 1'b1;
		end
		check_count++;
		if (seen) begin
			check_outputs(exp_word, last_sel);
		end else begin
			err_count++;
			$display("Missing strobe: no dbgreg_strobe within %0d cycles of the update at %0t",
				STROBE_LIMIT, $time);
		end
		repeat (HALF_TCK) @(negedge clk48m);
		jtck      = 1'b0;
		jupdate   = 1'b0;
		last_word = exp_word;
	endtask

	task automatic run_scan(input dr_word_t word, input logic ce1, input logic ce2);
		int count0;
		count0 = strobe_count;
		shift_word(word, ce1, ce2);
		update_word(word);
		check_strobe_count(count0 + 1);
	endtask

	task automatic reset_state;
		check_outputs('0, 1'b0);
		repeat (50) begin
			@(negedge clk48m);
			check_count++;
			if (dbgreg_strobe !== 1'b0) begin
				err_count++;
				$display("[FAIL] %0t: dbgreg_strobe high without tck activity", $time);
			end
		end
	endtask

	task automatic fixed_scans;
		run_scan(32'hA5C3_0F96, 1'b1, 1'b0);
		run_scan(32'h0000_0001, 1'b1, 1'b0);
	endtask

	task automatic random_scans;
		dr_word_t word;
		for (int n = 0; n < 8; n++) begin
			word = $random(seed);
			run_scan(word, 1'b1, 1'b0);
		end
	endtask

	task automatic chain_select;
		run_scan(32'h1234_5678, 1'b0, 1'b1); // second chain
		run_scan(32'h9ABC_DEF0, 1'b1, 1'b0); // first chain
		run_scan(32'h0F0F_F0F0, 1'b0, 1'b0); // select kept low
		run_scan(32'hCAFE_0001, 1'b0, 1'b1);
		run_scan(32'h7E57_7E57, 1'b0, 1'b0); // select kept high
	endtask

	task automatic missing_update;
		dr_word_t prev;
		dr_word_t fresh;
		int       count0;
		prev  = last_word;
		fresh = $random(seed);
		if (fresh == prev)
			fresh = ~fresh;
		count0 = strobe_count;
		shift_word(fresh, 1'b0, 1'b0);
		repeat (HALF_TCK) @(negedge clk48m);
		check_strobe_count(count0);
		check_outputs(prev, last_sel);
		update_word(fresh); // update-only rise
		check_strobe_count(count0 + 1);
	endtask

	task automatic hold_without_shift;
		int count0;
		count0 = strobe_count;
		jshift = 1'b0;
		repeat (3) begin
			jtdi = ($random(seed) & 1) != 0;
			tck_pulse();
		end
		jtdi = 1'b0;
		update_word(last_word);
		check_strobe_count(count0 + 1);
	endtask

	initial begin
		seed      = 54906;
		jrstn     = 1'b0;
		jtck      = 1'b0;
		jtdi      = 1'b0;
		jshift    = 1'b0;
		jupdate   = 1'b0;
		jce1      = 1'b0;
		jce2      = 1'b0;
		last_word = '0;
		last_sel  = 1'b0;
		repeat (2) @(negedge clk48m);
		jrstn = 1'b1;

		reset_state();
		fixed_scans();
		random_scans();
		chain_select();
		missing_update();
		hold_without_shift();

		$display("checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// watchdog, sized from the number of scans
	initial begin
		#(TIMEOUT);
		$display("Timeout: run did not finish within %0d time units", TIMEOUT);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/jtag_dbg_bridge.sv ====
// JTAG debug register bridge
`default_nettype none

module jtag_dbg_bridge #(
	parameter int SYNC_STAGES   = bridge_cfg_pkg::SYNC_STAGES_DEF,
	parameter int SETTLE_CYCLES = bridge_cfg_pkg::SETTLE_DEF
) (
	input  logic               clk48m,
	input  logic               jrstn,
	input  logic               jtck,    // async JTAG pins from here
	input  logic               jtdi,
	input  logic               jshift,
	input  logic               jupdate,
	input  logic               jce1,
	input  logic               jce2,
	output jtag_pkg::dr_word_t dbgreg_in,
	output logic               dbgreg_sel,   // 1 when the second chain was used
	output logic               dbgreg_strobe // one cycle per update
);

	logic sample_tick;

	jtag_dr_if dr_if ();

	tck_edge_timer #(
		.SYNC_STAGES   (SYNC_STAGES),
		.SETTLE_CYCLES (SETTLE_CYCLES)
	) tck_edge_timer_inst (
		.clk48m      (clk48m),
		.jrstn       (jrstn),
		.jtck        (jtck),
		.sample_tick (sample_tick)
	);

	jtag_dr_ctrl #(
		.SYNC_STAGES (SYNC_STAGES)
	) jtag_dr_ctrl_inst (
		.clk48m      (clk48m),
		.jrstn       (jrstn),
		.sample_tick (sample_tick),
		.jshift      (jshift),
		.jupdate     (jupdate),
		.jce1        (jce1),
		.jce2        (jce2),
		.dr          (dr_if.ctrl)
	);

	jtag_dr_path #(
		.SYNC_STAGES (SYNC_STAGES)
	) jtag_dr_path_inst (
		.clk48m        (clk48m),
		.jrstn         (jrstn),
		.jtdi          (jtdi),
		.dr            (dr_if.path),
		.dbgreg_in     (dbgreg_in),
		.dbgreg_sel    (dbgreg_sel),
		.dbgreg_strobe (dbgreg_strobe)
	);

endmodule

`default_nettype wire

// ==== hdl/jtag_dr_path.sv ====
// JTAG DR data path
`default_nettype none

module jtag_dr_path #(
	parameter int SYNC_STAGES = bridge_cfg_pkg::SYNC_STAGES_DEF
) (
	input  logic               clk48m,
	input  logic               jrstn,
	input  logic               jtdi,
	jtag_dr_if.path            dr,
	output jtag_pkg::dr_word_t dbgreg_in,
	output logic               dbgreg_sel,
	output logic               dbgreg_strobe
);
	import jtag_pkg::*;

	localparam dr_pos_t TOP = dr_pos_t'(DR_WIDTH - 1);

	logic [SYNC_STAGES-1:0] tdi_sync; // same delay as tck and control pins
	logic                   tdi_s;
	dr_word_t               dr_shift;
	logic                   sel_q;    // last chain select seen

	assign tdi_s = tdi_sync[SYNC_STAGES-1];

	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			tdi_sync      <= '0;
			dr_shift      <= '0;
			sel_q         <= 1'b0;
			dbgreg_in     <= '0;
			dbgreg_sel    <= 1'b0;
			dbgreg_strobe <= 1'b0;
		end else begin
			tdi_sync      <= {tdi_sync[SYNC_STAGES-2:0], jtdi};
			dbgreg_strobe <= dr.update_en;
			if (dr.shift_en)
				dr_shift <= {tdi_s, dr_shift[TOP:1]}; // LSB first, ends up in bit 0
			if (dr.sel_load)
				sel_q <= dr.sel_value;
			if (dr.update_en) begin
				// values from before this cycle's shift and select load
				dbgreg_in  <= dr_shift;
				dbgreg_sel <= sel_q;
			end
		end
	end

	// update_en comes from a one-cycle FSM state, so the strobe is a pulse
	a_strobe_single: assert property (
		@(posedge clk48m) disable iff (!jrstn)
		dbgreg_strobe |=> !dbgreg_strobe
	) else $error("dbgreg_strobe high for two cycles");

endmodule

`default_nettype wire

// ==== hdl/jtag_dr_ctrl.sv ====
// JTAG DR controller
`default_nettype none

module jtag_dr_ctrl #(
	parameter int SYNC_STAGES = bridge_cfg_pkg::SYNC_STAGES_DEF
) (
	input  logic    clk48m,
	input  logic    jrstn,
	input  logic    sample_tick,
	input  logic    jshift,
	input  logic    jupdate,
	input  logic    jce1,
	input  logic    jce2,
	jtag_dr_if.ctrl dr
);
	import jtag_pkg::*;

	// {jshift, jupdate, jce1, jce2} per stage, same depth as tck
	logic [SYNC_STAGES-1:0][3:0] pin_sync;
	logic                        shift_s;
	logic                        update_s;
	logic                        ce1_s;
	logic                        ce2_s;
	dr_state_t                   state;
	dr_state_t                   state_next;

	assign {shift_s, update_s, ce1_s, ce2_s} = pin_sync[SYNC_STAGES-1];

	always_comb begin
		state_next = state;
		if (sample_tick) begin
			if (update_s)
				state_next = st_update;
			else if (shift_s)
				state_next = st_shift; // arms shifting for the next tick
			else
				state_next = st_idle;
		end else if (state == st_update) begin
			state_next = st_idle; // update lasts one cycle only
		end
	end

	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			pin_sync     <= '0;
			state        <= st_idle;
			dr.shift_en  <= 1'b0;
			dr.sel_load  <= 1'b0;
			dr.sel_value <= 1'b0;
		end else begin
			pin_sync     <= {pin_sync[SYNC_STAGES-2:0], {jshift, jupdate, jce1, jce2}};
			state        <= state_next;
			dr.shift_en  <= sample_tick && (state == st_shift); // jshift at previous tick
			dr.sel_load  <= sample_tick && (ce1_s || ce2_s);
			dr.sel_value <= sample_tick && ce2_s;
		end
	end

	// st_update is entered on the tick edge, so this lines up with the other commands
	assign dr.update_en = (state == st_update);

	// every command belongs to the tick one cycle earlier
	a_cmd_after_tick: assert property (
		@(posedge clk48m) disable iff (!jrstn)
		(dr.shift_en || dr.sel_load || dr.update_en) |-> $past(sample_tick)
	) else $error("DR command without a preceding sample tick");

endmodule

`default_nettype wire

// ==== hdl/tck_edge_timer.sv ====
// TCK edge timer
`default_nettype none

module tck_edge_timer #(
	parameter int SYNC_STAGES   = bridge_cfg_pkg::SYNC_STAGES_DEF,
	parameter int SETTLE_CYCLES = bridge_cfg_pkg::SETTLE_DEF
) (
	input  logic clk48m,
	input  logic jrstn,
	input  logic jtck,
	output logic sample_tick
);
	import bridge_cfg_pkg::*;

	localparam settle_cnt_t SETTLE_LOAD = settle_cnt_t'(SETTLE_CYCLES);

	logic [SYNC_STAGES-1:0] tck_sync; // bit 0 sees the raw pin
	logic                   tck_prev;
	logic                   tck_rise;
	settle_cnt_t            settle_cnt; // nonzero while waiting

	assign tck_rise = tck_sync[SYNC_STAGES-1] & ~tck_prev;

	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			tck_sync    <= '0;
			tck_prev    <= 1'b0;
			settle_cnt  <= '0;
			sample_tick <= 1'b0;
		end else begin
			tck_sync    <= {tck_sync[SYNC_STAGES-2:0], jtck};
			tck_prev    <= tck_sync[SYNC_STAGES-1];
			sample_tick <= 1'b0;
			if (tck_rise) begin
				// a fresh rise always restarts the wait
				settle_cnt <= SETTLE_LOAD;
				if (SETTLE_LOAD == '0)
					sample_tick <= 1'b1; // no settle, sample right away
			end else if (settle_cnt != '0) begin
				settle_cnt <= settle_cnt - 1'b1;
				if (settle_cnt == settle_cnt_t'(1))
					sample_tick <= 1'b1; // last settle cycle
			end
		end
	end

	// tck is far slower than clk48m, so one rise gives one single-cycle tick
	a_tick_single: assert property (
		@(posedge clk48m) disable iff (!jrstn)
		sample_tick |=> !sample_tick
	) else $error("sample_tick high for two cycles");

endmodule

`default_nettype wire

// ==== hdl/jtag_dr_if.sv ====
// DR command interface
`default_nettype none

interface jtag_dr_if;

	logic shift_en;  // shift tdi into the top of the word
	logic sel_load;  // store sel_value as chain select
	logic sel_value; // 1 selects the second user chain
	logic update_en; // copy word and select to the system side

	// FSM side
	modport ctrl (
		output shift_en, sel_load, sel_value, update_en
	);

	// data register side, always accepts
	modport path (
		input shift_en, sel_load, sel_value, update_en
	);

endinterface

`default_nettype wire

// ==== hdl/bridge_cfg_pkg.sv ====
// Bridge sampling timing
`default_nettype none

package bridge_cfg_pkg;

	// flops between the async JTAG pins and clk48m logic
	localparam int SYNC_STAGES_DEF = 2;

	// clk48m cycles to wait after a seen tck rise before sampling
	localparam int SETTLE_DEF = 2;

	// wide enough for settle values 0..15
	typedef logic [3:0] settle_cnt_t;

endpackage

`default_nettype wire

// ==== hdl/jtag_pkg.sv ====
// JTAG data register types
`default_nettype none

package jtag_pkg;

	// user DR length, matches the system debug word
	localparam int DR_WIDTH = 32;

	// register contents as seen on both sides of the bridge
	typedef logic [DR_WIDTH-1:0] dr_word_t;

	// index of a single bit inside the word
	typedef logic [$clog2(DR_WIDTH)-1:0] dr_pos_t;

	// register tracking FSM
	typedef enum logic [1:0] {
		st_idle   = 2'd0, // no shift armed
		st_shift  = 2'd1, // jshift seen, next tick shifts
		st_update = 2'd2  // one cycle, hands word to system
	} dr_state_t;

endpackage

`default_nettype wire
